// ==== Makefile ====
# Verilator build and run for the Wishbone register subsystem testbench

VERILATOR ?= verilator
TOP       ?= tbTop
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_MSG  ?= Simulation PASSED

SIM := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell cat $(FLIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# Fails unless the pass line shows up in the simulator output
run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== flist.f ====
fpgaPkg.sv
wbReqDecode.sv
fpgaRegisters.sv
fpgaTimer.sv
wbReadReturn.sv
fpgaTop.sv
tbChecker.sv
tbTop.sv

// ==== fpgaPkg.sv ====
/*
 * Shared definitions for the Wishbone register subsystem.
 * Bus widths, register map, reset constants and the request types
 * passed between the decoder, register bank, timer and read return.
 */
package fpgaPkg;

    // --------------------------------------------------------------------------
    // Bus widths
    // --------------------------------------------------------------------------
    localparam int ADDR_W = 7;                      // Up to 128 word registers
    localparam int DATA_W = 32;
    localparam int BE_W   = DATA_W / 8;             // One strobe per byte lane

    // Register word addresses
    localparam logic [ADDR_W-1:0] ID_ADR         = 7'h00;
    localparam logic [ADDR_W-1:0] REV_ADR        = 7'h01;
    localparam logic [ADDR_W-1:0] SCRATCH_ADR    = 7'h02;
    localparam logic [ADDR_W-1:0] TMR_CTRL_ADR   = 7'h03;
    localparam logic [ADDR_W-1:0] TMR_RELOAD_ADR = 7'h04;   // Last bank address
    localparam logic [ADDR_W-1:0] TMR_COUNT_ADR  = 7'h05;   // First timer address
    localparam logic [ADDR_W-1:0] TMR_STAT_ADR   = 7'h06;   // Last mapped address

    // Bit positions inside the control and status words
    localparam int CTRL_EN_BIT    = 0;
    localparam int CTRL_IRQEN_BIT = 1;
    localparam int STAT_PEND_BIT  = 0;              // Write 1 clears

    // --------------------------------------------------------------------------
    // Constants and reset values
    // --------------------------------------------------------------------------
    localparam logic [19:0]       DEVICE_ID     = 20'h0AEC2;
    localparam logic [15:0]       REV_LEVEL     = 16'h0002;
    localparam logic [DATA_W-1:0] SCRATCH_RESET = 32'h1234_5678;
    localparam logic [DATA_W-1:0] DEFAULT_RD    = 32'hFABD_EFAC;   // Unmapped reads

    // Target of a decoded request
    typedef enum logic [1:0] {
        REGION_BANK  = 2'd0,                        // ID, revision, scratch, control
        REGION_TIMER = 2'd1,                        // Count and status
        REGION_NONE  = 2'd2                         // Everything above
    } regionE;

    // One captured bus cycle, 46 bits
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic [BE_W-1:0]   be;
        logic              we;
        regionE            region;
    } wbReqT;

    // Timer settings held in the register bank, 34 bits
    typedef struct packed {
        logic              enable;
        logic              irqEnable;
        logic [DATA_W-1:0] reload;
    } tmrCtrlT;

endpackage

// ==== fpgaRegisters.sv ====
/*
 * Register bank.
 * Read-only ID and revision, byte-writable scratch register, and the
 * timer control and reload registers handed on to the timer.
 */
`timescale 1ns/1ps

module fpgaRegisters
    import fpgaPkg::*;
(
    input  logic              WBs_CLK_i,
    input  logic              WBs_RST_i,
    input  logic              reqValid_i,
    input  wbReqT             req_i,
    output tmrCtrlT           tmrCtrl_o,
    output logic [DATA_W-1:0] bankRdData_o
);

    logic [DATA_W-1:0] scratchReg;
    logic [DATA_W-1:0] reloadReg;
    logic              ctrlEn;                      // Timer runs
    logic              ctrlIrqEn;                   // Pending reaches the IRQ pin
    logic              bankWr;

    // Replace only the strobed byte lanes of a word
    function automatic logic [DATA_W-1:0] mergeBytes(
        input logic [DATA_W-1:0] oldWord,
        input logic [DATA_W-1:0] newWord,
        input logic [BE_W-1:0]   byteEn
    );
        logic [DATA_W-1:0] merged;
        merged = oldWord;
        for (int i = 0; i < BE_W; i++)
        begin
            if (byteEn[i])
                merged[8*i +: 8] = newWord[8*i +: 8];
        end
        return merged;
    endfunction

    // Bank writes only, other regions never touch these registers
    assign bankWr = reqValid_i & req_i.we & (req_i.region == REGION_BANK);

    // --------------------------------------------------------------------------
    // Writable registers
    // --------------------------------------------------------------------------
    always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i)
    begin
        if (WBs_RST_i)
        begin
            scratchReg <= SCRATCH_RESET;
            reloadReg  <= '0;
            ctrlEn     <= 1'b0;                     // Timer off after reset
            ctrlIrqEn  <= 1'b0;
        end
        else if (bankWr)
        begin
            case (req_i.addr)
                SCRATCH_ADR:
                begin
                    scratchReg <= mergeBytes(scratchReg, req_i.wdata, req_i.be);
                end
                TMR_RELOAD_ADR:
                begin
                    reloadReg <= mergeBytes(reloadReg, req_i.wdata, req_i.be);
                end
                TMR_CTRL_ADR:
                begin
                    // Both control bits live in byte 0
                    if (req_i.be[0])
                    begin
                        ctrlEn    <= req_i.wdata[CTRL_EN_BIT];
                        ctrlIrqEn <= req_i.wdata[CTRL_IRQEN_BIT];
                    end
                end
                default:
                begin
                    // ID and revision are read-only
                end
            endcase
        end
    end

    // Settings to the timer
    assign tmrCtrl_o.enable    = ctrlEn;
    assign tmrCtrl_o.irqEnable = ctrlIrqEn;
    assign tmrCtrl_o.reload    = reloadReg;

    // --------------------------------------------------------------------------
    // Read mux, straight from the captured address
    // --------------------------------------------------------------------------
    always_comb
    begin
        bankRdData_o = DEFAULT_RD;
        case (req_i.addr)
            ID_ADR:         bankRdData_o = {12'h000, DEVICE_ID};   // Zero-extended
            REV_ADR:        bankRdData_o = {16'h0000, REV_LEVEL};
            SCRATCH_ADR:    bankRdData_o = scratchReg;
            TMR_CTRL_ADR:
            begin
                bankRdData_o                 = '0;
                bankRdData_o[CTRL_EN_BIT]    = ctrlEn;
                bankRdData_o[CTRL_IRQEN_BIT] = ctrlIrqEn;
            end
            TMR_RELOAD_ADR: bankRdData_o = reloadReg;
            default:        bankRdData_o = DEFAULT_RD;  // Not a bank address
        endcase
    end

endmodule

// ==== fpgaTimer.sv ====
/*
 * Interval timer.
 * Down counter that reloads on reaching zero and sets a sticky pending
 * flag, cleared by writing 1 to bit 0 of the status word.
 */
`timescale 1ns/1ps

module fpgaTimer
    import fpgaPkg::*;
(
    input  logic              WBs_CLK_i,
    input  logic              WBs_RST_i,
    input  logic              reqValid_i,
    input  wbReqT             req_i,
    input  tmrCtrlT           tmrCtrl_i,
    output logic [DATA_W-1:0] timerRdData_o,
    output logic              timerIrq_o
);

    logic [DATA_W-1:0] count;
    logic              pending;
    logic              atZero;
    logic              clrPend;

    assign atZero = (count == '0);

    // Write 1 to status bit 0, byte lane 0 must be strobed
    assign clrPend = reqValid_i & req_i.we
                   & (req_i.region == REGION_TIMER)
                   & (req_i.addr == TMR_STAT_ADR)
                   & req_i.be[0]
                   & req_i.wdata[STAT_PEND_BIT];

    // --------------------------------------------------------------------------
    // Counter
    // --------------------------------------------------------------------------
    always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i)
    begin
        if (WBs_RST_i)
        begin
            count <= '0;
        end
        else if (!tmrCtrl_i.enable)
        begin
            count <= tmrCtrl_i.reload;              // Idle, preload for next start
        end
        else if (atZero)
        begin
            count <= tmrCtrl_i.reload;              // Wrap
        end
        else
        begin
            count <= count - 1;
        end
    end

    // Sticky flag, a wrap in the same cycle as a clear wins
    always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i)
    begin
        if (WBs_RST_i)
            pending <= 1'b0;
        else if (tmrCtrl_i.enable && atZero)
            pending <= 1'b1;
        else if (clrPend)
            pending <= 1'b0;
    end

    assign timerIrq_o = pending & tmrCtrl_i.irqEnable;     // Masked interrupt

    // Count or status by captured address
    always_comb
    begin
        if (req_i.addr == TMR_COUNT_ADR)
        begin
            timerRdData_o = count;
        end
        else
        begin
            timerRdData_o                = '0;
            timerRdData_o[STAT_PEND_BIT] = pending;
        end
    end

endmodule

// ==== fpgaTop.sv ====
/*
 * Wishbone register subsystem top level.
 * Decoder, register bank, timer and read return wired together.
 */
`timescale 1ns/1ps

module fpgaTop
    import fpgaPkg::*;
(
    input  logic              WBs_CLK_i,
    input  logic              WBs_RST_i,
    input  logic [ADDR_W-1:0] WBs_ADR_i,
    input  logic              WBs_CYC_i,
    input  logic              WBs_STB_i,
    input  logic              WBs_WE_i,
    input  logic [BE_W-1:0]   WBs_BYTE_STB_i,
    input  logic [DATA_W-1:0] WBs_DAT_i,
    output logic [DATA_W-1:0] WBs_DAT_o,
    output logic              WBs_ACK_o,
    output logic              timerIrq_o
);

    logic              reqValid;                    // One cycle per bus cycle
    wbReqT             req;
    tmrCtrlT           tmrCtrl;
    logic [DATA_W-1:0] bankRdData;
    logic [DATA_W-1:0] timerRdData;

    // Input side
    wbReqDecode wbReqDecode_inst (
        .WBs_CLK_i      (WBs_CLK_i),
        .WBs_RST_i      (WBs_RST_i),
        .WBs_ADR_i      (WBs_ADR_i),
        .WBs_CYC_i      (WBs_CYC_i),
        .WBs_STB_i      (WBs_STB_i),
        .WBs_WE_i       (WBs_WE_i),
        .WBs_BYTE_STB_i (WBs_BYTE_STB_i),
        .WBs_DAT_i      (WBs_DAT_i),
        .reqValid_o     (reqValid),
        .req_o          (req)
    );

    // Processing
    fpgaRegisters fpgaRegisters_inst (
        .WBs_CLK_i    (WBs_CLK_i),
        .WBs_RST_i    (WBs_RST_i),
        .reqValid_i   (reqValid),
        .req_i        (req),
        .tmrCtrl_o    (tmrCtrl),
        .bankRdData_o (bankRdData)
    );

    fpgaTimer fpgaTimer_inst (
        .WBs_CLK_i     (WBs_CLK_i),
        .WBs_RST_i     (WBs_RST_i),
        .reqValid_i    (reqValid),
        .req_i         (req),
        .tmrCtrl_i     (tmrCtrl),
        .timerRdData_o (timerRdData),
        .timerIrq_o    (timerIrq_o)
    );

    // Output side
    wbReadReturn wbReadReturn_inst (
        .WBs_CLK_i     (WBs_CLK_i),
        .WBs_RST_i     (WBs_RST_i),
        .reqValid_i    (reqValid),
        .region_i      (req.region),
        .bankRdData_i  (bankRdData),
        .timerRdData_i (timerRdData),
        .WBs_DAT_o     (WBs_DAT_o),
        .WBs_ACK_o     (WBs_ACK_o)
    );

endmodule

// ==== tbChecker.sv ====
/*
 * Testbench checker.
 * Watches the Wishbone port and the IRQ pin on the falling edge, keeps
 * a model of the writable registers and the pending flag, compares all.
 */
`timescale 1ns/1ps

module tbChecker
    import fpgaPkg::*;
(
    input  logic              WBs_CLK_i,
    input  logic              WBs_RST_i,
    input  logic [ADDR_W-1:0] adr_i,
    input  logic              cyc_i,
    input  logic              stb_i,
    input  logic              we_i,
    input  logic [BE_W-1:0]   be_i,
    input  logic [DATA_W-1:0] wrData_i,
    input  logic [DATA_W-1:0] rdData_i,
    input  logic              ack_i,
    input  logic              irq_i,
    output int                dataErr_o,
    output int                ackErr_o,
    output int                checkCount_o,
    output int                ackCount_o
);

    logic [DATA_W-1:0] scratchM;                    // Register model
    logic [DATA_W-1:0] reloadM;
    logic              enM;
    logic              irqEnM;
    logic              pendM;
    logic              pendKnown;                   // Low while a wrap may be on its way
    logic [DATA_W-1:0] runCycles;                   // Since the timer was started
    int                cycPos;                      // Falling edges since STB went high
    logic              inCycle;

    // Strobed bytes from the new word, the rest kept
    function automatic logic [DATA_W-1:0] laneMerge(
        input logic [DATA_W-1:0] oldW,
        input logic [DATA_W-1:0] newW,
        input logic [BE_W-1:0]   be
    );
        logic [DATA_W-1:0] mask;
        for (int i = 0; i < BE_W; i++)
            mask[8*i +: 8] = {8{be[i]}};
        return (oldW & ~mask) | (newW & mask);
    endfunction

    function automatic logic [DATA_W-1:0] expectedRead(input logic [ADDR_W-1:0] a);
        logic [DATA_W-1:0] val;
        val = '0;
        case (a)
            ID_ADR:         val = DATA_W'(DEVICE_ID);
            REV_ADR:        val = DATA_W'(REV_LEVEL);
            SCRATCH_ADR:    val = scratchM;
            TMR_RELOAD_ADR: val = reloadM;
            TMR_CTRL_ADR:
            begin
                val[CTRL_EN_BIT]    = enM;
                val[CTRL_IRQEN_BIT] = irqEnM;
            end
            TMR_STAT_ADR:   val[STAT_PEND_BIT] = pendM;
            default:        val = DEFAULT_RD;       // Whole unmapped window
        endcase
        return val;
    endfunction

    task automatic flagMismatch(
        input string             sig,
        input logic [DATA_W-1:0] expV,
        input logic [DATA_W-1:0] gotV
    );
        $display("MISMATCH time=%0t signal=%s expected=%h got=%h", $time, sig, expV, gotV);
        dataErr_o++;
    endtask

    task automatic ackFault(input string what);
        $display("Error at %0t: %s", $time, what);
        ackErr_o++;
    endtask

    // --------------------------------------------------------------------------
    // Model updates on an acknowledged write
    // --------------------------------------------------------------------------
    task automatic applyWrite();
        case (adr_i)
            SCRATCH_ADR:    scratchM = laneMerge(scratchM, wrData_i, be_i);
            TMR_RELOAD_ADR: reloadM  = laneMerge(reloadM, wrData_i, be_i);
            TMR_CTRL_ADR:
            begin
                if (be_i[0])
                begin
                    if (wrData_i[CTRL_EN_BIT] && !enM && !pendM)
                    begin
                        pendKnown = 1'b0;           // Starts counting
                        runCycles = '0;
                    end
                    enM    = wrData_i[CTRL_EN_BIT];
                    irqEnM = wrData_i[CTRL_IRQEN_BIT];
                end
            end
            TMR_STAT_ADR:
            begin
                if (be_i[0] && wrData_i[STAT_PEND_BIT])
                begin
                    pendM     = 1'b0;
                    pendKnown = !enM;               // Running timer sets it again
                    runCycles = '0;
                end
            end
            default:
            begin
                // ID, revision, count and unmapped words ignore writes
            end
        endcase
    endtask

    task automatic checkRead();
        if (adr_i == TMR_COUNT_ADR)
        begin
            checkCount_o++;
            if (rdData_i > reloadM)
                flagMismatch("WBs_DAT_o(count above reload)", reloadM, rdData_i);
        end
        else if (adr_i != TMR_STAT_ADR || pendKnown)
        begin
            checkCount_o++;
            if (rdData_i !== expectedRead(adr_i))
                flagMismatch($sformatf("WBs_DAT_o(adr %0d)", adr_i),
                             expectedRead(adr_i), rdData_i);
        end
    endtask

    always @(negedge WBs_CLK_i)
    begin
        if (WBs_RST_i)
        begin
            scratchM     = SCRATCH_RESET;
            reloadM      = '0;
            enM          = 1'b0;
            irqEnM       = 1'b0;
            pendM        = 1'b0;
            pendKnown    = 1'b1;
            runCycles    = '0;
            cycPos       = 0;
            inCycle      = 1'b0;
            dataErr_o    = 0;
            ackErr_o     = 0;
            checkCount_o = 0;
            ackCount_o   = 0;
        end
        else
        begin
            // Wrap is certain once reload+2 cycles have passed
            if (enM && !pendKnown)
            begin
                runCycles++;
                if (runCycles > reloadM + 2)
                begin
                    pendKnown = 1'b1;
                    pendM     = 1'b1;
                end
            end

            if (ack_i && !stb_i)
                ackFault("ACK seen while STB is low");
            if (cyc_i && stb_i)
            begin
                cycPos  = inCycle ? cycPos + 1 : 0;
                inCycle = 1'b1;
                if (ack_i)
                begin
                    ackCount_o++;
                    if (cycPos != 2)
                        ackFault($sformatf("ACK came %0d cycles after STB, not 2", cycPos));
                    if (we_i)
                        applyWrite();
                    else
                        checkRead();
                end
                else if (cycPos == 2)
                begin
                    ackFault("no ACK two cycles after STB was sampled");
                end
            end
            else
            begin
                inCycle = 1'b0;
            end

            // Pin checked between bus cycles, once the model is settled
            if (!stb_i && (pendKnown || !irqEnM))
            begin
                checkCount_o++;
                if (irq_i !== (pendM & irqEnM))
                    flagMismatch("timerIrq_o", {31'b0, pendM & irqEnM}, {31'b0, irq_i});
            end
        end
    end

endmodule

// ==== tbTop.sv ====
/*
 * Testbench top for the Wishbone register subsystem.
 * Clock, reset, random bus cycles from a fixed seed, run timeout and
 * the per-test summary. All response checks live in tbChecker.
 */
`timescale 1ns/1ps

module tbTop
    import fpgaPkg::*;
();

    localparam logic [31:0] SEED       = 32'h5fd50f5c;
    localparam int          N_BYTE     = 40;            // Write plus read-back pairs
    localparam int          N_UNMAP    = 20;            // Unmapped write plus read pairs
    localparam int          MAX_RELOAD = 12;
    localparam int          N_TIMER    = 16;            // Timer test bus cycles, upper bound
    localparam int          N_TXN      = 3 + 2*N_BYTE + 2*N_UNMAP + 7 + N_TIMER;
    localparam int          WAIT_WIN   = 2 * (MAX_RELOAD + 4);  // Two timer windows
    localparam int          MAX_CYCLES = N_TXN*8 + WAIT_WIN + 100;

    logic              WBs_CLK_i;
    logic              WBs_RST_i;
    logic [ADDR_W-1:0] WBs_ADR_i;
    logic              WBs_CYC_i;
    logic              WBs_STB_i;
    logic              WBs_WE_i;
    logic [BE_W-1:0]   WBs_BYTE_STB_i;
    logic [DATA_W-1:0] WBs_DAT_i;
    logic [DATA_W-1:0] WBs_DAT_o;
    logic              WBs_ACK_o;
    logic              timerIrq_o;

    int                dataErr;                     // From the checker
    int                ackErr;
    int                checkCount;
    int                ackCount;
    int                cycleCount;
    int                testsRun;
    int                testsFailed;
    int                errMark;                     // dataErr at start of current test
    logic [DATA_W-1:0] rnd;
    logic [DATA_W-1:0] reloadVal;
    logic [ADDR_W-1:0] adr;

    fpgaTop fpgaTop_inst (
        .WBs_CLK_i      (WBs_CLK_i),
        .WBs_RST_i      (WBs_RST_i),
        .WBs_ADR_i      (WBs_ADR_i),
        .WBs_CYC_i      (WBs_CYC_i),
        .WBs_STB_i      (WBs_STB_i),
        .WBs_WE_i       (WBs_WE_i),
        .WBs_BYTE_STB_i (WBs_BYTE_STB_i),
        .WBs_DAT_i      (WBs_DAT_i),
        .WBs_DAT_o      (WBs_DAT_o),
        .WBs_ACK_o      (WBs_ACK_o),
        .timerIrq_o     (timerIrq_o)
    );

    tbChecker tbChecker_inst (
        .WBs_CLK_i    (WBs_CLK_i),
        .WBs_RST_i    (WBs_RST_i),
        .adr_i        (WBs_ADR_i),
        .cyc_i        (WBs_CYC_i),
        .stb_i        (WBs_STB_i),
        .we_i         (WBs_WE_i),
        .be_i         (WBs_BYTE_STB_i),
        .wrData_i     (WBs_DAT_i),
        .rdData_i     (WBs_DAT_o),
        .ack_i        (WBs_ACK_o),
        .irq_i        (timerIrq_o),
        .dataErr_o    (dataErr),
        .ackErr_o     (ackErr),
        .checkCount_o (checkCount),
        .ackCount_o   (ackCount)
    );

    always #5 WBs_CLK_i = ~WBs_CLK_i;               // 10 ns period

    // Run limit
    always @(posedge WBs_CLK_i)
    begin
        cycleCount++;
        if (cycleCount > MAX_CYCLES)
        begin
            $display("Timeout after %0d cycles, a bus cycle never completed", cycleCount);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // --------------------------------------------------------------------------
    // Bus cycle, inputs change 1 ns after the edge
    // --------------------------------------------------------------------------
    task automatic busCycle(
        input logic [ADDR_W-1:0] a,
        input logic              w,
        input logic [BE_W-1:0]   be,
        input logic [DATA_W-1:0] d
    );
        @(posedge WBs_CLK_i);
        #1;
        WBs_ADR_i      = a;
        WBs_WE_i       = w;
        WBs_BYTE_STB_i = be;
        WBs_DAT_i      = d;
        WBs_CYC_i      = 1'b1;
        WBs_STB_i      = 1'b1;
        @(negedge WBs_CLK_i);
        while (WBs_ACK_o !== 1'b1)
            @(negedge WBs_CLK_i);                   // Held stable until ACK
        @(posedge WBs_CLK_i);
        #1;
        WBs_CYC_i = 1'b0;
        WBs_STB_i = 1'b0;
        WBs_WE_i  = 1'b0;
    endtask

    task automatic busRead(input logic [ADDR_W-1:0] a);
        busCycle(a, 1'b0, '1, '0);
    endtask

    task automatic busWrite(
        input logic [ADDR_W-1:0] a,
        input logic [BE_W-1:0]   be,
        input logic [DATA_W-1:0] d
    );
        busCycle(a, 1'b1, be, d);
    endtask

    // One result line per test
    task automatic endTest(input int num, input string name);
        testsRun++;
        if (dataErr == errMark)
        begin
            $display("Test %0d %s: PASS", num, name);
        end
        else
        begin
            testsFailed++;
            $display("Test %0d %s: FAIL, %0d errors", num, name, dataErr - errMark);
        end
        errMark = dataErr;
    endtask

    initial
    begin
        WBs_CLK_i      = 1'b0;
        WBs_RST_i      = 1'b1;
        WBs_ADR_i      = '0;
        WBs_CYC_i      = 1'b0;
        WBs_STB_i      = 1'b0;
        WBs_WE_i       = 1'b0;
        WBs_BYTE_STB_i = '0;
        WBs_DAT_i      = '0;
        cycleCount     = 0;
        testsRun       = 0;
        testsFailed    = 0;
        errMark        = 0;
        rnd            = $urandom(SEED);            // Seeds the generator once
        repeat (4) @(posedge WBs_CLK_i);
        #1;
        WBs_RST_i = 1'b0;

        // Reset values and constants
        busRead(ID_ADR);
        busRead(REV_ADR);
        busRead(SCRATCH_ADR);
        endTest(1, "reset and constants");

        // Random byte-lane writes, each read back
        for (int i = 0; i < N_BYTE; i++)
        begin
            adr = ($urandom % 2) ? SCRATCH_ADR : TMR_RELOAD_ADR;
            busWrite(adr, BE_W'($urandom % 16), $urandom);
            busRead(adr);
        end
        endTest(2, "byte-lane writes");

        // Unmapped window 7 to 127
        for (int i = 0; i < N_UNMAP; i++)
        begin
            adr = ADDR_W'(7 + ($urandom % 121));
            busWrite(adr, BE_W'($urandom % 16), $urandom);
            busRead(adr);
        end
        for (int a = 0; a <= 6; a++)
            busRead(ADDR_W'(a));                    // Mapped registers untouched
        endTest(3, "unmapped addresses");

        // Timer, first with the IRQ enabled, then masked
        reloadVal = 2 + ($urandom % (MAX_RELOAD - 1));
        busWrite(TMR_RELOAD_ADR, '1, reloadVal);
        busWrite(TMR_CTRL_ADR, 4'h1, 32'h3);
        repeat (reloadVal + 4) @(posedge WBs_CLK_i);
        busRead(TMR_STAT_ADR);
        repeat (3) busRead(TMR_COUNT_ADR);
        busWrite(TMR_CTRL_ADR, 4'h1, 32'h2);        // Stop, IRQ still enabled
        busWrite(TMR_STAT_ADR, 4'h1, 32'h1);        // Clear, pin drops
        busRead(TMR_STAT_ADR);
        busWrite(TMR_CTRL_ADR, 4'h1, 32'h1);        // Run with IRQ masked
        repeat (reloadVal + 4) @(posedge WBs_CLK_i);
        busRead(TMR_STAT_ADR);
        busWrite(TMR_CTRL_ADR, 4'h1, 32'h0);
        busWrite(TMR_STAT_ADR, 4'h1, 32'h1);
        busRead(TMR_STAT_ADR);
        endTest(5, "timer and interrupt");

        // ACK timing, watched over the whole run
        testsRun++;
        if (ackErr == 0)
        begin
            $display("Test 4 acknowledge: PASS, %0d ACKs", ackCount);
        end
        else
        begin
            testsFailed++;
            $display("Test 4 acknowledge: FAIL, %0d errors", ackErr);
        end

        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 testsRun, testsFailed, checkCount, dataErr + ackErr);
        if (testsFailed == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

// ==== wbReadReturn.sv ====
/*
 * Read return path.
 * Picks bank, timer or default read data by region and registers it
 * together with a one-cycle acknowledge.
 */
`timescale 1ns/1ps

module wbReadReturn
    import fpgaPkg::*;
(
    input  logic              WBs_CLK_i,
    input  logic              WBs_RST_i,
    input  logic              reqValid_i,
    input  regionE            region_i,
    input  logic [DATA_W-1:0] bankRdData_i,
    input  logic [DATA_W-1:0] timerRdData_i,
    output logic [DATA_W-1:0] WBs_DAT_o,
    output logic              WBs_ACK_o
);

    logic [DATA_W-1:0] rdNext;

    // Source select
    always_comb
    begin
        case (region_i)
            REGION_BANK:  rdNext = bankRdData_i;
            REGION_TIMER: rdNext = timerRdData_i;
            default:      rdNext = DEFAULT_RD;      // Unmapped window
        endcase
    end

    // --------------------------------------------------------------------------
    // Acknowledge, one per request
    // --------------------------------------------------------------------------
    always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i)
    begin
        if (WBs_RST_i)
            WBs_ACK_o <= 1'b0;
        else
            WBs_ACK_o <= reqValid_i;
    end

    // Read data lines up with ACK
    always_ff @(posedge WBs_CLK_i)
    begin
        if (reqValid_i)
            WBs_DAT_o <= rdNext;
    end

endmodule

// ==== wbReqDecode.sv ====
/*
 * Wishbone request decoder.
 * Captures one bus cycle per STB assertion, classifies its address
 * into a region and issues a single-cycle request strobe.
 */
`timescale 1ns/1ps

module wbReqDecode
    import fpgaPkg::*;
(
    input  logic              WBs_CLK_i,
    input  logic              WBs_RST_i,
    input  logic [ADDR_W-1:0] WBs_ADR_i,
    input  logic              WBs_CYC_i,
    input  logic              WBs_STB_i,
    input  logic              WBs_WE_i,
    input  logic [BE_W-1:0]   WBs_BYTE_STB_i,
    input  logic [DATA_W-1:0] WBs_DAT_i,
    output logic              reqValid_o,
    output wbReqT             req_o
);

    logic   busy;                                   // Cycle taken, wait for STB low
    logic   accept;
    regionE regionNext;

    // New cycle only when idle
    assign accept = WBs_CYC_i & WBs_STB_i & ~busy;

    // Address classification, done once here for all consumers
    always_comb
    begin
        if (WBs_ADR_i <= TMR_RELOAD_ADR)
        begin
            regionNext = REGION_BANK;
        end
        else if (WBs_ADR_i <= TMR_STAT_ADR)
        begin
            regionNext = REGION_TIMER;
        end
        else
        begin
            regionNext = REGION_NONE;               // Reads default, writes dropped
        end
    end

    // --------------------------------------------------------------------------
    // Handshake state
    // --------------------------------------------------------------------------
    always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i)
    begin
        if (WBs_RST_i)
        begin
            busy       <= 1'b0;
            reqValid_o <= 1'b0;
        end
        else
        begin
            reqValid_o <= accept;                   // High for one cycle only
            if (accept)
                busy <= 1'b1;
            else if (!WBs_STB_i)
                busy <= 1'b0;                       // Host ended the cycle
        end
    end

    // Captured request, host holds it stable until ACK
    always_ff @(posedge WBs_CLK_i)
    begin
        if (accept)
        begin
            req_o.addr   <= WBs_ADR_i;
            req_o.wdata  <= WBs_DAT_i;
            req_o.be     <= WBs_BYTE_STB_i;
            req_o.we     <= WBs_WE_i;
            req_o.region <= regionNext;
        end
    end

endmodule
